// File: logic/apb_delay_pkg.sv
package apb_delay_pkg;

    // bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = 4;
    localparam int prot_width = 3;
    localparam int byte_offset_bits = 2;

    // fixed-point delay ratio, slow/fast ratio minus one
    localparam int ratio_frac_bits = 10;
    localparam int delay_count_width = 48;
    localparam logic [delay_count_width-1:0] delay_ratio_default =
        delay_count_width'(9) << ratio_frac_bits;

    // completer geometry
    localparam int mem_words = 64;
    localparam int mem_index_width = $clog2(mem_words);

    // wait states come from paddr[4:2]
    localparam int wait_field_lsb = 2;
    localparam int wait_field_width = 3;

    // FSM encodings
    localparam int state_width = 2;

    localparam logic [state_width-1:0] req_idle = 2'd0;
    localparam logic [state_width-1:0] req_setup = 2'd1;
    localparam logic [state_width-1:0] req_access = 2'd2;

    localparam logic [state_width-1:0] dly_idle = 2'd0;
    localparam logic [state_width-1:0] dly_active = 2'd1;
    localparam logic [state_width-1:0] dly_delay = 2'd2;

endpackage

// File: logic/apb_if.sv
`timescale 1ns/1ps

interface apb_if;
    import apb_delay_pkg::*;

    // request side
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic [prot_width-1:0] pprot;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [strb_width-1:0] pstrb;

    // response side
    logic                  pready;
    logic [data_width-1:0] prdata;
    logic                  pslverr;

    modport requester (
        output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

// File: logic/apb_requester.sv
`timescale 1ns/1ps

module apb_requester (
    input  logic                                    clock,
    input  logic                                    reset,

    input  logic                                    cmd_valid,
    output logic                                    cmd_ready,
    input  logic [apb_delay_pkg::addr_width-1:0]    cmd_addr,
    input  logic                                    cmd_write,
    input  logic [apb_delay_pkg::data_width-1:0]    cmd_wdata,
    input  logic [apb_delay_pkg::strb_width-1:0]    cmd_strb,

    output logic                                    rsp_valid,
    input  logic                                    rsp_ready,
    output logic [apb_delay_pkg::data_width-1:0]    rsp_rdata,
    output logic                                    rsp_error,

    apb_if.requester                                bus
);
    import apb_delay_pkg::*;

    logic [state_width-1:0] state;
    logic                   cmd_fire;
    logic                   bus_done;

    // a pending response blocks the next command
    assign cmd_ready = (state == req_idle) && !rsp_valid;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign bus_done  = (state == req_access) && bus.pready;

    // protection attributes are not used
    assign bus.pprot = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= req_idle;
            bus.psel    <= 1'b0;
            bus.penable <= 1'b0;
            rsp_valid   <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end

            case (state)
                req_idle: begin
                    if (cmd_fire) begin
                        bus.psel <= 1'b1;
                        state    <= req_setup;
                    end
                end
                req_setup: begin
                    bus.penable <= 1'b1;
                    state       <= req_access;
                end
                req_access: begin
                    // hold the access phase until the completer answers
                    if (bus.pready) begin
                        bus.psel    <= 1'b0;
                        bus.penable <= 1'b0;
                        rsp_valid   <= 1'b1;
                        state       <= req_idle;
                    end
                end
                default: begin
                    bus.psel    <= 1'b0;
                    bus.penable <= 1'b0;
                    state       <= req_idle;
                end
            endcase
        end
    end

    // command payload, stable on the bus until completion
    always_ff @(posedge clock) begin
        if (cmd_fire) begin
            bus.paddr  <= cmd_addr;
            bus.pwrite <= cmd_write;
            bus.pwdata <= cmd_wdata;
            bus.pstrb  <= cmd_strb;
        end
    end

    // response payload
    always_ff @(posedge clock) begin
        if (bus_done) begin
            rsp_rdata <= bus.prdata;
            rsp_error <= bus.pslverr;
        end
    end

endmodule

// File: logic/apb_delayer.sv
`timescale 1ns/1ps

module apb_delayer #(
    parameter logic [apb_delay_pkg::delay_count_width-1:0] delay_ratio =
        apb_delay_pkg::delay_ratio_default
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        delay_enable,

    apb_if.completer    up,
    apb_if.requester    down
);
    import apb_delay_pkg::*;

    logic [state_width-1:0]       state;
    logic                         delay_mode;
    logic [delay_count_width-1:0] delay_count;
    logic                         up_ready_q;
    logic [data_width-1:0]        hold_rdata;
    logic                         hold_slverr;
    logic                         setup_seen;
    logic                         block_down;

    assign setup_seen = up.psel && !up.penable;

    // keep the completer quiet while the answer is held back
    assign block_down = (state == dly_delay) || up_ready_q;

    // request payload is forwarded as is
    assign down.paddr  = up.paddr;
    assign down.pprot  = up.pprot;
    assign down.pwrite = up.pwrite;
    assign down.pwdata = up.pwdata;
    assign down.pstrb  = up.pstrb;

    assign down.psel    = up.psel && !block_down;
    assign down.penable = up.penable && !block_down;

    // response is either direct or replayed after the countdown
    assign up.pready  = delay_mode ? up_ready_q : down.pready;
    assign up.prdata  = delay_mode ? hold_rdata : down.prdata;
    assign up.pslverr = delay_mode ? hold_slverr : down.pslverr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= dly_idle;
            delay_mode  <= 1'b0;
            delay_count <= '0;
            up_ready_q  <= 1'b0;
        end else begin
            up_ready_q <= 1'b0;

            case (state)
                dly_idle: begin
                    // mode only changes between transfers
                    if (setup_seen) begin
                        delay_mode <= delay_enable;
                        state      <= dly_active;
                    end
                end
                dly_active: begin
                    if (down.pready) begin
                        if (delay_mode) begin
                            // drop the fraction, keep whole core cycles
                            delay_count <= delay_count >> ratio_frac_bits;
                            state       <= dly_delay;
                        end else begin
                            state <= dly_idle;
                        end
                    end else if (delay_mode) begin
                        delay_count <= delay_count + delay_ratio;
                    end
                end
                dly_delay: begin
                    if (delay_count == '0) begin
                        up_ready_q <= 1'b1;
                        state      <= dly_idle;
                    end else begin
                        delay_count <= delay_count - 1'b1;
                    end
                end
                default: begin
                    delay_count <= '0;
                    state       <= dly_idle;
                end
            endcase
        end
    end

    // answer captured at the device completion
    always_ff @(posedge clock) begin
        if ((state == dly_active) && down.pready) begin
            hold_rdata  <= down.prdata;
            hold_slverr <= down.pslverr;
        end
    end

endmodule

// File: logic/apb_wait_memory.sv
`timescale 1ns/1ps

module apb_wait_memory (
    input  logic        clock,
    input  logic        reset,

    apb_if.completer    bus
);
    import apb_delay_pkg::*;

    logic [data_width-1:0]                  mem [mem_words];
    logic [wait_field_width-1:0]            wait_count;
    logic [addr_width-byte_offset_bits-1:0] word_addr;
    logic [mem_index_width-1:0]             mem_index;
    logic                                   in_range;
    logic                                   setup;
    logic                                   access;

    assign setup  = bus.psel && !bus.penable;
    assign access = bus.psel && bus.penable;

    assign word_addr = bus.paddr[addr_width-1:byte_offset_bits];
    assign mem_index = word_addr[mem_index_width-1:0];
    assign in_range  = (int'(word_addr) < mem_words);

    // ready once the wait count has run out
    assign bus.pready = access && (wait_count == '0);

    // read data and error only in the completing cycle
    assign bus.prdata  = (bus.pready && !bus.pwrite && in_range) ? mem[mem_index] : '0;
    assign bus.pslverr = bus.pready && !in_range;

    // wait states
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (setup) begin
            wait_count <= bus.paddr[wait_field_lsb +: wait_field_width];
        end else if (access && (wait_count != '0)) begin
            wait_count <= wait_count - 1'b1;
        end
    end

    // storage, written byte by byte on completion
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.pready && bus.pwrite && in_range) begin
            for (int b = 0; b < strb_width; b++) begin
                if (bus.pstrb[b]) begin
                    mem[mem_index][8*b +: 8] <= bus.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: logic/apb_delay_top.sv
`timescale 1ns/1ps

module apb_delay_top (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    delay_enable,

    // command channel
    input  logic                                    cmd_valid,
    output logic                                    cmd_ready,
    input  logic [apb_delay_pkg::addr_width-1:0]    cmd_addr,
    input  logic                                    cmd_write,
    input  logic [apb_delay_pkg::data_width-1:0]    cmd_wdata,
    input  logic [apb_delay_pkg::strb_width-1:0]    cmd_strb,

    // response channel
    output logic                                    rsp_valid,
    input  logic                                    rsp_ready,
    output logic [apb_delay_pkg::data_width-1:0]    rsp_rdata,
    output logic                                    rsp_error
);

    // requester to delayer
    apb_if up_bus ();

    // delayer to memory
    apb_if dev_bus ();

    apb_requester u_requester (
        .clock     (clock),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_addr  (cmd_addr),
        .cmd_write (cmd_write),
        .cmd_wdata (cmd_wdata),
        .cmd_strb  (cmd_strb),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_error (rsp_error),
        .bus       (up_bus.requester)
    );

    apb_delayer u_delayer (
        .clock        (clock),
        .reset        (reset),
        .delay_enable (delay_enable),
        .up           (up_bus.completer),
        .down         (dev_bus.requester)
    );

    apb_wait_memory u_memory (
        .clock (clock),
        .reset (reset),
        .bus   (dev_bus.completer)
    );

endmodule

// File: sim/apb_delay_tb.sv
`timescale 1ns/1ps

module apb_delay_tb;
    import apb_delay_pkg::*;

    // run length
    localparam int num_random = 400;
    localparam int model_words = 64;
    localparam int num_sweep = model_words;
    localparam int index_range = 80;
    localparam int reset_cycles = 10;

    // device wait states are stretched by this many core cycles each
    localparam int extra_per_wait = 9;

    // bounds used for the run limit
    localparam int max_gap = 3;
    localparam int max_stall = 4;
    localparam int worst_latency = 7 + 5 + 63;
    localparam int stall_allowance = max_gap + max_stall + 2;
    localparam int cycle_limit =
        2 * ((num_random + num_sweep) * (worst_latency + stall_allowance)) + reset_cycles;

    logic                  clock;
    logic                  reset;
    logic                  delay_enable;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic [addr_width-1:0] cmd_addr;
    logic                  cmd_write;
    logic [data_width-1:0] cmd_wdata;
    logic [strb_width-1:0] cmd_strb;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [data_width-1:0] rsp_rdata;
    logic                  rsp_error;

    logic [31:0] lfsr_state;
    int          cycle = 0;
    logic [31:0] model_mem [model_words];
    int          last_write_index;

    apb_delay_top UUT (
        .clock        (clock),
        .reset        (reset),
        .delay_enable (delay_enable),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_addr     (cmd_addr),
        .cmd_write    (cmd_write),
        .cmd_wdata    (cmd_wdata),
        .cmd_strb     (cmd_strb),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_rdata    (rsp_rdata),
        .rsp_error    (rsp_error)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // cycle count, also the time base for latency
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic random_flag();
        logic [31:0] value;
        value = random_bits(1);
        return value[0];
    endfunction

    // wait field is the low three bits of the word index
    function automatic int expected_latency(input int index, input logic delayed);
        int waits;
        int cycles;
        waits = index % 8;
        if (delayed) begin
            cycles = waits + 5 + extra_per_wait * waits;
        end else begin
            cycles = waits + 3;
        end
        return cycles;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // one command through to its taken response
    task automatic run_transfer(input int index, input logic write,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                input logic delayed, input logic flip);
        logic        exp_error;
        logic [31:0] exp_rdata;
        int          accept_cycle;
        int          stall;
        string       latency_name;

        // model, out of range gives an error and no write
        exp_error = (index >= model_words);
        exp_rdata = '0;
        if (!exp_error && !write) begin
            exp_rdata = model_mem[index];
        end
        if (!exp_error && write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_mem[index][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        latency_name = delayed ? "latency delayed" : "latency transparent";

        cmd_valid    <= 1'b1;
        cmd_addr     <= addr_width'(index) << 2;
        cmd_write    <= write;
        cmd_wdata    <= wdata;
        cmd_strb     <= strb;
        delay_enable <= delayed;

        do begin
            @(posedge clock);
        end while (!cmd_ready);
        accept_cycle = cycle;
        cmd_valid <= 1'b0;

        // delayer has sampled the mode by now, so a change here is for later
        @(posedge clock);
        if (flip) begin
            delay_enable <= !delayed;
        end

        while (!rsp_valid) begin
            check_value("cmd_ready busy", 32'(1'b0), 32'(cmd_ready));
            rsp_ready <= random_flag();
            @(posedge clock);
        end

        check_value(latency_name, expected_latency(index, delayed), cycle - accept_cycle);
        check_value("cmd_ready busy", 32'(1'b0), 32'(cmd_ready));
        check_value("slave error", 32'(exp_error), 32'(rsp_error));
        check_value("read data", exp_rdata, rsp_rdata);

        // back-pressure, bounded so the run limit holds
        stall = 0;
        while (!rsp_ready) begin
            stall++;
            rsp_ready <= (stall >= max_stall) ? 1'b1 : random_flag();
            @(posedge clock);
            check_value("rsp_valid held", 32'(1'b1), 32'(rsp_valid));
            check_value("rsp_rdata held", exp_rdata, rsp_rdata);
            check_value("rsp_error held", 32'(exp_error), 32'(rsp_error));
            check_value("cmd_ready busy", 32'(1'b0), 32'(cmd_ready));
        end
    endtask

    initial begin
        int          gap;
        int          kind;
        int          index;
        logic        write;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        delayed;
        logic        flip;

        lfsr_state   = 32'hee2d;
        reset        = 1'b1;
        delay_enable = 1'b0;
        cmd_valid    = 1'b0;
        cmd_addr     = '0;
        cmd_write    = 1'b0;
        cmd_wdata    = '0;
        cmd_strb     = '0;
        rsp_ready    = 1'b0;
        last_write_index = 0;
        for (int i = 0; i < model_words; i++) begin
            model_mem[i] = '0;
        end

        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_value("cmd_ready after reset", 32'(1'b1), 32'(cmd_ready));
        check_value("rsp_valid after reset", 32'(1'b0), 32'(rsp_valid));

        for (int n = 0; n < num_random; n++) begin
            gap = random_bits(2);
            repeat (gap) @(posedge clock);

            // kind 0 reads back the last write, also the alias of an out of range one
            kind  = random_bits(2);
            index = random_bits(7) % index_range;
            if (kind == 0) begin
                index = last_write_index % model_words;
            end
            write   = (kind >= 2);
            wdata   = random_bits(32);
            strb    = random_bits(4);
            delayed = random_flag();
            flip    = random_flag();
            if (write) begin
                last_write_index = index;
            end
            run_transfer(index, write, wdata, strb, delayed, flip);
        end

        // every word once more at the end
        for (int i = 0; i < num_sweep; i++) begin
            run_transfer(i, 1'b0, '0, '0, 1'b0, 1'b0);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: apb_delay_top.f
logic/apb_delay_pkg.sv
logic/apb_if.sv
logic/apb_requester.sv
logic/apb_delayer.sv
logic/apb_wait_memory.sv
logic/apb_delay_top.sv
sim/apb_delay_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f apb_delay_top.f \
    --top-module apb_delay_tb -o apb_delay_sim &&
./obj_dir/apb_delay_sim | grep -F "*** TEST PASSED ***" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
